// ==== filelist.f ====
+incdir+include
hdl/video_pkg.sv
hdl/video_timing.sv
hdl/video_render.sv
hdl/video_palette.sv
hdl/video_top.sv
verification/video_top_tb.sv

// ==== Bender.yml ====
package:
  name: video_backend

sources:
  - include_dirs:
      - include
    files:
      - hdl/video_pkg.sv
      - hdl/video_timing.sv
      - hdl/video_render.sv
      - hdl/video_palette.sv
      - hdl/video_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/video_top_tb.sv

// ==== verification/video_top_tb.sv ====
// testbench for the video back end: pixel decode, layer priority, palette and frame timing
`include "video_macros.svh"

module video_top_tb import video_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int FRAME_CYC = `H_TOTAL * `V_TOTAL;

	logic         clk;
	logic         reset;
	render_ctrl_t ctrl;
	logic [31:0]  data;
	logic [7:0]   border;
	logic [7:0]   tsdata;
	logic         pal_we;
	logic [7:0]   pal_addr;
	rgb_t         pal_wdata;
	logic [7:0]   vplex;
	rgb_t         rgb;
	logic         frame_start;

	integer       seed;
	int           vplex_errs = 0;
	int           rgb_errs = 0;
	int           frame_errs = 0;
	int           other_errs = 0;

	// model state, mirrors the raster counters and the palette
	int           m_h;
	int           m_v;
	logic [3:0]   m_hr;
	rgb_t         mirror [`PAL_DEPTH];
	logic [7:0]   exp_vplex;
	rgb_t         exp_rgb;
	bit           vplex_valid = 0;
	bit           rgb_valid = 0;
	bit           rgb_check_en = 0;

	video_top video_top_inst (
		.clk         (clk),
		.reset       (reset),
		.ctrl        (ctrl),
		.data        (data),
		.border      (border),
		.tsdata      (tsdata),
		.pal_we      (pal_we),
		.pal_addr    (pal_addr),
		.pal_wdata   (pal_wdata),
		.vplex       (vplex),
		.rgb         (rgb),
		.frame_start (frame_start)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// index before hi-res packing
	function automatic logic [7:0] pixel_index(input int h, input int v, input render_ctrl_t c,
			input logic [31:0] d, input logic [7:0] bord, input logic [7:0] ts);
		int         p;
		logic       dot;
		logic [7:0] attr;
		logic [3:0] nib;
		logic [7:0] gfx;
		logic       set;
		logic       ts_on;
		p = h % `WORD_PIX;
		if (!(h < `H_ACTIVE && v < `V_ACTIVE)) begin
			return bord;
		end
		// leftmost dot is the msb of each bitmap byte
		dot = d[(p / 8) * 8 + (7 - p % 8)];
		attr = d[16 + (p / 8) * 8 +: 8];
		case (c.mode)
			R_ZX: begin
				set = dot ^ (c.flash & attr[7]);
				gfx = {c.palsel, attr[6], set ? attr[2:0] : attr[5:3]};
			end
			R_TX: begin
				set = dot;
				gfx = {c.palsel, dot ? attr[3:0] : attr[7:4]};
			end
			R_HC: begin
				// nibble order 7:4, 3:0, 15:12, 11:8
				nib = d[((p % 4) / 2) * 8 + ((p % 2) ? 0 : 4) +: 4];
				set = (nib != 4'd0);
				gfx = {c.palsel, nib};
			end
			default: begin
				gfx = d[(p % 2) * 8 +: 8];
				set = (gfx != 8'd0);
			end
		endcase
		ts_on = (ts[3:0] != 4'd0) && !c.notsu;
		if (c.gfxovr) begin
			if (set && !c.nogfx) begin
				return gfx;
			end
			return ts_on ? ts : bord;
		end
		if (ts_on) begin
			return ts;
		end
		return c.nogfx ? bord : gfx;
	endfunction

	// expected vplex including the hi-res upper nibble
	function automatic logic [7:0] ref_vplex(input logic [7:0] video, input logic hires,
			input logic [3:0] hr);
		return hires ? {hr, video[3:0]} : video;
	endfunction

	function automatic rgb_t ref_rgb(input logic [7:0] idx);
		return mirror[idx];
	endfunction

	task automatic compare_vplex(input logic [7:0] exp_val, input logic [7:0] act_val);
		if (act_val !== exp_val) begin
			$display("MISMATCH t=%0t vplex exp=%h act=%h", $time, exp_val, act_val);
			vplex_errs++;
		end
	endtask

	task automatic compare_rgb(input rgb_t exp_val, input rgb_t act_val);
		if (act_val !== exp_val) begin
			$display("MISMATCH t=%0t rgb exp=%h act=%h", $time, exp_val, act_val);
			rgb_errs++;
		end
	endtask

	task automatic compare_flag(input logic exp_val, input logic act_val);
		if (act_val !== exp_val) begin
			$display("MISMATCH t=%0t frame_start exp=%b act=%b", $time, exp_val, act_val);
			frame_errs++;
		end
	endtask

	// outputs settle well before the falling edge
	always @(negedge clk) begin : compare_proc
		logic [7:0] video;
		if (vplex_valid) begin
			compare_vplex(exp_vplex, vplex);
		end
		if (rgb_valid && rgb_check_en) begin
			compare_rgb(exp_rgb, rgb);
		end
		if (reset) begin
			m_h = 0;
			m_v = 0;
			m_hr = 4'd0;
			exp_vplex = 8'd0;
			exp_rgb = '0;
			vplex_valid = 1;
			rgb_valid = 1;
		end else begin
			compare_flag((m_h == 0) && (m_v == 0), frame_start);
			exp_rgb = ref_rgb(exp_vplex);
			rgb_valid = vplex_valid;
			video = pixel_index(m_h, m_v, ctrl, data, border, tsdata);
			exp_vplex = ref_vplex(video, ctrl.hires, m_hr);
			if (m_h % 2 == 0) begin
				m_hr = video[3:0];
			end
			m_h = (m_h + 1) % `H_TOTAL;
			if (m_h == 0) begin
				m_v = (m_v + 1) % `V_TOTAL;
			end
		end
	end

	task automatic load_palette();
		int a;
		for (a = 0; a < `PAL_DEPTH; a++) begin
			@(posedge clk);
			#2;
			pal_we = 1'b1;
			pal_addr = a;
			pal_wdata = $random(seed);
			mirror[a] = pal_wdata;
		end
		@(posedge clk);
		#2;
		pal_we = 1'b0;
	endtask

	// new word and layer flags at the start of each 16-pixel group
	task automatic run_cycles(input int n, input render_ctrl_t base, input bit rand_layers,
			input bit attr_flash, input bit rand_ts);
		int i;
		for (i = 0; i < n; i++) begin
			@(posedge clk);
			#2;
			if (m_h % `WORD_PIX == 0) begin
				data = $random(seed);
				if (attr_flash) begin
					data[31] = 1'b1;
					data[23] = 1'b1;
				end
				ctrl = base;
				if (rand_layers) begin
					ctrl.nogfx = $random(seed);
					ctrl.notsu = $random(seed);
					ctrl.gfxovr = $random(seed);
				end
			end
			border = $random(seed);
			tsdata = rand_ts ? $random(seed) : 8'd0;
		end
	endtask

	task automatic wait_frame(output int cycles);
		int limit;
		bit seen;
		limit = 2 * FRAME_CYC + 4;
		seen = 0;
		cycles = 0;
		while (!seen && cycles < limit) begin
			@(negedge clk);
			cycles++;
			seen = frame_start;
		end
		if (!seen) begin
			$display("timeout: frame_start did not pulse within %0d cycles", limit);
			other_errs++;
		end
	endtask

	initial begin : stimulus
		render_ctrl_t base;
		int gap;
		int i;
		seed = 32'h35bfbf80;
		reset = 1'b1;
		ctrl = '0;
		data = 32'd0;
		border = 8'd0;
		tsdata = 8'd0;
		pal_we = 1'b0;
		pal_addr = 8'd0;
		pal_wdata = '0;
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;

		load_palette();
		repeat (3) @(posedge clk);
		rgb_check_en = 1;

		// frame strobe spacing
		wait_frame(gap);
		wait_frame(gap);
		if (gap != FRAME_CYC) begin
			$display("frame_start period was %0d cycles instead of %0d", gap, FRAME_CYC);
			frame_errs++;
		end

		// each mode alone, graphics only
		for (i = 0; i < 4; i++) begin
			base = '0;
			base.mode = render_mode_t'(i);
			base.palsel = $random(seed);
			run_cycles(2 * FRAME_CYC, base, 1'b0, 1'b0, 1'b0);
		end

		// tiles and sprites against graphics, both priority orders
		for (i = 0; i < 4; i++) begin
			base = '0;
			base.mode = render_mode_t'(i);
			base.palsel = $random(seed);
			run_cycles(2 * FRAME_CYC, base, 1'b1, 1'b0, 1'b1);
		end

		// flash swaps ink and paper in zx, text ignores it
		base = '0;
		base.mode = R_ZX;
		base.flash = 1'b1;
		run_cycles(2 * FRAME_CYC, base, 1'b0, 1'b1, 1'b0);
		base.mode = R_TX;
		run_cycles(2 * FRAME_CYC, base, 1'b0, 1'b1, 1'b0);

		// hi-res packing in every mode
		for (i = 0; i < 4; i++) begin
			base = '0;
			base.mode = render_mode_t'(i);
			base.hires = 1'b1;
			base.palsel = $random(seed);
			run_cycles(FRAME_CYC, base, 1'b1, 1'b0, 1'b1);
		end

		repeat (4) @(posedge clk);
		$display("errors: vplex %0d, rgb %0d, frame %0d, other %0d",
			vplex_errs, rgb_errs, frame_errs, other_errs);
		if (vplex_errs + rgb_errs + frame_errs + other_errs == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== hdl/video_top.sv ====
// video back end: raster timing, pixel renderer and colour palette
module video_top import video_pkg::*; (
	input  logic         clk,
	input  logic         reset,

	// renderer controls and fetched data
	input  render_ctrl_t ctrl,
	input  logic [31:0]  data,
	input  logic [7:0]   border,
	input  logic [7:0]   tsdata,

	// palette write port
	input  logic         pal_we,
	input  logic [7:0]   pal_addr,
	input  rgb_t         pal_wdata,

	// pixel index and colour out
	output logic [7:0]   vplex,
	output rgb_t         rgb,
	output logic         frame_start
);

	pix_pos_t pos;

	video_timing video_timing_inst (
		.clk         (clk),
		.reset       (reset),
		.pos         (pos),
		.frame_start (frame_start)
	);

	// index registered one cycle after pos
	video_render video_render_inst (
		.clk    (clk),
		.reset  (reset),
		.pos    (pos),
		.ctrl   (ctrl),
		.data   (data),
		.border (border),
		.tsdata (tsdata),
		.vplex  (vplex)
	);

	// colour one cycle after the index
	video_palette video_palette_inst (
		.clk   (clk),
		.reset (reset),
		.vplex (vplex),
		.we    (pal_we),
		.waddr (pal_addr),
		.wdata (pal_wdata),
		.rgb   (rgb)
	);

endmodule

// ==== hdl/video_palette.sv ====
// colour palette RAM: cpu write port and registered pixel colour lookup
`include "video_macros.svh"

module video_palette import video_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	input  logic [`PAL_AW-1:0]  vplex,
	input  logic                we,
	input  logic [`PAL_AW-1:0]  waddr,
	input  rgb_t                wdata,
	output rgb_t                rgb
);

	rgb_t mem [`PAL_DEPTH];

	// cpu side, one entry per strobe
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// pixel side lookup, old data on a same-address write
	always_ff @(posedge clk) begin
		if (reset) begin
			rgb <= '0;
		end else begin
			rgb <= mem[vplex];
		end
	end

	// a write must land on a defined entry
	waddr_known_a: assert property (
		@(posedge clk) disable iff (reset)
		we |-> !$isunknown(waddr)
	) else $error("palette write with unknown address");

	// renderer index is defined once out of reset
	vplex_known_a: assert property (
		@(posedge clk) disable iff (reset)
		!$past(reset) |-> !$isunknown(vplex)
	) else $error("palette read index unknown");

endmodule

// ==== hdl/video_render.sv ====
// pixel renderer: per-mode decode, layer priority and hi-res packing
module video_render import video_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  pix_pos_t     pos,
	input  render_ctrl_t ctrl,
	input  logic [31:0]  data,
	input  logic [7:0]   border,
	input  logic [7:0]   tsdata,
	output logic [7:0]   vplex
);

	logic [15:0] gfx_word;
	logic [15:0] atr_word;
	logic        zx_dot;
	logic [7:0]  zx_attr;
	logic        zx_set;
	logic [7:0]  zx_pix;
	logic [7:0]  tx_pix;
	logic [3:0]  hc_dot;
	logic [7:0]  hc_pix;
	logic [7:0]  xc_pix;
	logic [7:0]  gfx_pix;
	logic        gfx_set;
	logic        ts_vis;
	logic        gfx_vis;
	logic [7:0]  layer_ts;
	logic [7:0]  layer_gfx;
	logic [7:0]  video;
	logic [3:0]  hr_nib;

	// zx and text share the bitmap and attribute halves
	assign gfx_word = data[15:0];
	assign atr_word = data[31:16];
	// msb of each byte is the leftmost dot
	assign zx_dot   = gfx_word[{pos.psel[3], ~pos.psel[2:0]}];
	assign zx_attr  = pos.psel[3] ? atr_word[15:8] : atr_word[7:0];

	// flash swaps ink and paper
	assign zx_set = zx_dot ^ (ctrl.flash & zx_attr[7]);
	assign zx_pix = {ctrl.palsel, zx_attr[6], zx_set ? zx_attr[2:0] : zx_attr[5:3]};
	// text attribute is fg/bg nibbles
	assign tx_pix = {ctrl.palsel, zx_dot ? zx_attr[3:0] : zx_attr[7:4]};

	// 16c nibble order within the lower half-word
	always_comb begin
		case (pos.psel[1:0])
			2'd0: hc_dot = data[7:4];
			2'd1: hc_dot = data[3:0];
			2'd2: hc_dot = data[15:12];
			default: hc_dot = data[11:8];
		endcase
	end

	assign hc_pix = {ctrl.palsel, hc_dot};
	assign xc_pix = pos.psel[0] ? data[15:8] : data[7:0];

	// mode select, pixel and its set flag
	always_comb begin
		case (ctrl.mode)
			R_ZX: begin
				gfx_pix = zx_pix;
				gfx_set = zx_set;
			end
			R_HC: begin
				gfx_pix = hc_pix;
				gfx_set = |hc_dot;
			end
			R_XC: begin
				gfx_pix = xc_pix;
				gfx_set = |xc_pix;
			end
			default: begin
				gfx_pix = tx_pix;
				gfx_set = zx_dot;
			end
		endcase
	end

	// zero low nibble is transparent for tiles and sprites
	assign ts_vis  = (|tsdata[3:0]) && !ctrl.notsu;
	assign gfx_vis = gfx_set && !ctrl.nogfx;

	// tiles over graphics
	assign layer_ts  = ts_vis ? tsdata : (ctrl.nogfx ? border : gfx_pix);
	// graphics over tiles
	assign layer_gfx = gfx_vis ? gfx_pix : (ts_vis ? tsdata : border);
	assign video     = !pos.hvpix ? border : (ctrl.gfxovr ? layer_gfx : layer_ts);

	// hi-res keeps the even pixel for the upper nibble
	always_ff @(posedge clk) begin
		if (reset) begin
			hr_nib <= '0;
			vplex  <= '0;
		end else begin
			if (pos.c1) begin
				hr_nib <= video[3:0];
			end
			vplex <= ctrl.hires ? {hr_nib, video[3:0]} : video;
		end
	end

endmodule

// ==== hdl/video_timing.sv ====
// raster timing generator: pixel position, active window and frame strobe
`include "video_macros.svh"

module video_timing import video_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	output pix_pos_t pos,
	output logic     frame_start
);

	logic [`H_CNT_W-1:0] h_cnt;
	logic [`V_CNT_W-1:0] v_cnt;
	logic                h_last;
	logic                v_last;

	assign h_last = (h_cnt == (`H_TOTAL - 1));
	assign v_last = (v_cnt == (`V_TOTAL - 1));

	// horizontal count every clock, vertical at end of line
	always_ff @(posedge clk) begin
		if (reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			if (h_last) begin
				h_cnt <= '0;
				if (v_last) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// position follows the counters in the same cycle
	assign pos.psel  = h_cnt[3:0];
	assign pos.hvpix = (h_cnt < `H_ACTIVE) && (v_cnt < `V_ACTIVE);
	// even pixels, the half-rate strobe
	assign pos.c1    = ~h_cnt[0];

	assign frame_start = (h_cnt == '0) && (v_cnt == '0);

	// psel steps one pixel per clock and wraps at the word boundary
	psel_step_a: assert property (
		@(posedge clk) disable iff (reset)
		!$past(reset) |-> (pos.psel == $past(pos.psel) + 4'd1)
	) else $error("psel did not advance by one pixel");

	// no active pixel in the horizontal blank
	hvpix_window_a: assert property (
		@(posedge clk) disable iff (reset)
		(h_cnt >= `H_ACTIVE) |-> !pos.hvpix
	) else $error("hvpix high beyond the active width");

	// one frame strobe per full raster
	frame_period_a: assert property (
		@(posedge clk) disable iff (reset)
		frame_start |-> ##(`H_TOTAL * `V_TOTAL) frame_start
	) else $error("frame_start period is not one raster");

	// no early strobe inside a frame
	frame_single_a: assert property (
		@(posedge clk) disable iff (reset)
		frame_start |=> !frame_start [* (`H_TOTAL * `V_TOTAL - 1)]
	) else $error("extra frame_start inside a frame");

endmodule

// ==== hdl/video_pkg.sv ====
// video types: render modes, control word, pixel position and colour
package video_pkg;

	// graphics decode modes
	typedef enum logic [1:0] {
		R_ZX = 2'd0,
		R_HC = 2'd1,
		R_XC = 2'd2,
		R_TX = 2'd3
	} render_mode_t;

	// renderer control word, held as a level
	typedef struct packed {
		render_mode_t mode;
		// graphics layer off, border takes its place
		logic         nogfx;
		// tile/sprite layer off
		logic         notsu;
		// graphics drawn over tiles
		logic         gfxovr;
		// zx flash phase
		logic         flash;
		// two 4-bit pixels per index
		logic         hires;
		// upper nibble for zx, 16c and text
		logic [3:0]   palsel;
		logic [4:0]   spare;
	} render_ctrl_t;

	// 15-bit colour
	typedef struct packed {
		logic [4:0] r;
		logic [4:0] g;
		logic [4:0] b;
	} rgb_t;

	// position within the fetched word, from the timing generator
	typedef struct packed {
		logic [3:0] psel;
		logic       hvpix;
		logic       c1;
	} pix_pos_t;

endpackage

// ==== include/video_macros.svh ====
// video raster constants: frame geometry, counter widths and palette size
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// full raster, blanking included
`define H_TOTAL 32
`define V_TOTAL 8

// visible window, starting at count 0
`define H_ACTIVE 16
`define V_ACTIVE 4

// counter widths, sized to hold H_TOTAL-1 and V_TOTAL-1
`define H_CNT_W 5
`define V_CNT_W 3

// pixels per fetched 32-bit word
`define WORD_PIX 16

// colour lookup table
`define PAL_DEPTH 256
`define PAL_AW 8

`endif
